// ==== test/decode_cases.txt ====
# name inst rs1 rs2 rd wen alu src word br imm load store size uns mask jump jalr ebreak illegal
# all hex; alu 0 add..9 and, src 0 reg 1 imm 2 pc_imm 3 pc_four, br 0 none..6 geu
add     002081b3 1 2 3 1 0 0 0 0 0                0 0 0 0 00 0 0 0 0
sub     407302b3 6 7 5 1 1 0 0 0 0                0 0 0 0 00 0 0 0 0
sra     40c5d533 b c a 1 7 0 0 0 0                0 0 0 0 00 0 0 0 0
and     003170b3 2 3 1 1 9 0 0 0 0                0 0 0 0 00 0 0 0 0
sltu    0062b233 5 6 4 1 4 0 0 0 0                0 0 0 0 00 0 0 0 0
addi    fff10093 2 0 1 1 0 1 0 0 ffffffffffffffff 0 0 0 0 00 0 0 0 0
xori    7ff24193 4 0 3 1 5 1 0 0 7ff              0 0 0 0 00 0 0 0 0
slli    03f31293 6 0 5 1 2 1 0 0 3f               0 0 0 0 00 0 0 0 0
srai    40545393 8 0 7 1 7 1 0 0 405              0 0 0 0 00 0 0 0 0
slti    8000a093 1 0 1 1 3 1 0 0 fffffffffffff800 0 0 0 0 00 0 0 0 0
addw    003100bb 2 3 1 1 0 0 1 0 0                0 0 0 0 00 0 0 0 0
subw    4041813b 3 4 2 1 1 0 1 0 0                0 0 0 0 00 0 0 0 0
sraw    405251bb 4 5 3 1 7 0 1 0 0                0 0 0 0 00 0 0 0 0
addiw   0051009b 2 0 1 1 0 1 1 0 5                0 0 0 0 00 0 0 0 0
slliw   01f2119b 4 0 3 1 2 1 1 0 1f               0 0 0 0 00 0 0 0 0
sraiw   4033529b 6 0 5 1 7 1 1 0 403              0 0 0 0 00 0 0 0 0
lb      ffc10083 2 0 1 1 0 1 0 0 fffffffffffffffc 1 0 0 0 00 0 0 0 0
lh      00221183 4 0 3 1 0 1 0 0 2                1 0 1 0 00 0 0 0 0
lw      00832283 6 0 5 1 0 1 0 0 8                1 0 2 0 00 0 0 0 0
ld      01043383 8 0 7 1 0 1 0 0 10               1 0 3 0 00 0 0 0 0
lbu     00014083 2 0 1 1 0 1 0 0 0                1 0 0 1 00 0 0 0 0
lhu     00015083 2 0 1 1 0 1 0 0 0                1 0 1 1 00 0 0 0 0
lwu     00016083 2 0 1 1 0 1 0 0 0                1 0 2 1 00 0 0 0 0
sb      002080a3 1 2 0 0 0 1 0 0 1                0 1 0 0 01 0 0 0 0
sh      fe321f23 4 3 0 0 0 1 0 0 fffffffffffffffe 0 1 1 0 03 0 0 0 0
sw      02532023 6 5 0 0 0 1 0 0 20               0 1 2 0 0f 0 0 0 0
sd      00743423 8 7 0 0 0 1 0 0 8                0 1 3 0 ff 0 0 0 0
beq     00208463 1 2 0 0 1 0 0 1 8                0 0 0 0 00 0 0 0 0
bne     fe419ee3 3 4 0 0 1 0 0 2 fffffffffffffffc 0 0 0 0 00 0 0 0 0
blt     0062c863 5 6 0 0 3 0 0 3 10               0 0 0 0 00 0 0 0 0
bltu    0020e263 1 2 0 0 4 0 0 5 4                0 0 0 0 00 0 0 0 0
bgeu    0083f0e3 7 8 0 0 4 0 0 6 800              0 0 0 0 00 0 0 0 0
jal     001000ef 0 0 1 1 0 3 0 0 800              0 0 0 0 00 1 0 0 0
jal_x0  fffff06f 0 0 0 1 0 3 0 0 fffffffffffffffe 0 0 0 0 00 1 0 0 0
jalr    00c280e7 5 0 1 1 0 3 0 0 c                0 0 0 0 00 1 1 0 0
lui     80000137 0 0 2 1 0 1 0 0 ffffffff80000000 0 0 0 0 00 0 0 0 0
auipc   12345197 0 0 3 1 0 2 0 0 12345000         0 0 0 0 00 0 0 0 0
mul     023100b3 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
mulw    023100bb 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
zero    00000000 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
opc_7f  0000007f 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
jalr_f1 00c290e7 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
br_f2   0020a463 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
load_f7 00017083 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
st_f4   0020c0a3 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
slli_bad 40011093 0 0 0 0 0 0 0 0 0               0 0 0 0 00 0 0 0 1
ecall   00000073 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
csrrw   30001073 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 0 1
ebreak  00100073 0 0 0 0 0 0 0 0 0                0 0 0 0 00 0 0 1 0

// ==== filelist.f ====
logic/rv_decode_pkg.sv
logic/alu_decode.sv
logic/imm_gen.sv
logic/mem_decode.sv
logic/decode_ctrl.sv
logic/decode_top.sv
test/decode_assert.sv
test/decode_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the decode testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_tb -f filelist.f || exit 1

sim_out=$(./obj_dir/Vdecode_tb)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx '=== PASS ===' && exit 0 || exit 1

// ==== test/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;

    logic                       clk;
    logic                       arst_n;
    logic                       in_valid;
    logic                       in_ready;
    rv_decode_pkg::inst_t       inst;
    logic                       out_valid;
    logic                       out_ready;
    rv_decode_pkg::decode_out_t out;

    string                      names[$];
    rv_decode_pkg::inst_t       words[$];
    rv_decode_pkg::decode_out_t expected[$];
    int                         pending[$];     // case indices in flight
    int                         cur_idx = 0;    // case currently on inst
    logic                       accepted_q = 1'b0;
    int                         n_cases = 0;
    int                         n_checked = 0;
    int                         n_errors = 0;
    logic [31:0]                lcg_state = 32'h97f7_0edc;

    decode_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick_out_ready(input bit hold_high);
        lcg_state = lcg_next(lcg_state);
        out_ready = hold_high ? 1'b1 : lcg_state[16];
    endtask

    task automatic load_cases();
        int                         fd;
        int                         cnt;
        string                      line;
        string                      nm;
        logic [31:0]                w;
        logic [4:0]                 a, b, c;
        logic [3:0]                 aop;
        logic [1:0]                 src, sz;
        logic [2:0]                 br;
        logic [63:0]                im;
        logic [7:0]                 mk;
        logic                       wen, word, ld, st, un, jp, jr, eb, il;
        rv_decode_pkg::decode_out_t r;
        fd = $fopen("test/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            n_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          nm, w, a, b, c, wen, aop, src, word, br, im,
                          ld, st, sz, un, mk, jp, jr, eb, il);
            if (cnt <= 0) continue;              // blank line
            if (cnt != 20) begin
                $display("case line for %s has %0d fields instead of 20", nm, cnt);
                n_errors++;
                continue;
            end
            r             = '0;
            r.rs1         = a;
            r.rs2         = b;
            r.rd          = c;
            r.reg_wen     = wen;
            r.alu_op      = rv_decode_pkg::alu_op_e'(aop);
            r.src_sel     = rv_decode_pkg::src_sel_e'(src);
            r.word_op     = word;
            r.br_cond     = rv_decode_pkg::br_cond_e'(br);
            r.imm         = im;
            r.load        = ld;
            r.store       = st;
            r.size        = rv_decode_pkg::mem_size_e'(sz);
            r.unsigned_ld = un;
            r.byte_mask   = mk;
            r.jump        = jp;
            r.jalr        = jr;
            r.ebreak      = eb;
            r.illegal     = il;
            names.push_back(nm);
            words.push_back(w);
            expected.push_back(r);
        end
        $fclose(fd);
        n_cases = names.size();
    endtask

    // hold_high also checks one accept per cycle
    task automatic run_pass(input bit hold_high);
        int target;
        target = n_checked + n_cases;
        for (int i = 0; i < n_cases; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            inst     = words[i];
            cur_idx  = i;
            pick_out_ready(hold_high);
            #1;
            while (!in_ready) begin
                if (hold_high) begin
                    $display("in_ready low with out_ready held high at case %s", names[i]);
                    n_errors++;
                end
                @(negedge clk);
                pick_out_ready(hold_high);
                #1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        inst     = '0;
        while (n_checked < target) begin
            pick_out_ready(hold_high);
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        int idx;
        if (arst_n && accepted_q && !out_valid) begin
            $display("no record on out one cycle after an instruction was accepted");
            n_errors++;
        end
        if (arst_n && out_valid && out_ready) begin
            if (pending.size() == 0) begin
                $display("output record arrived with no instruction in flight");
                n_errors++;
            end else begin
                idx = pending.pop_front();
                n_checked++;
                if (out !== expected[idx]) begin
                    $display("error %s: expected %h, actual %h", names[idx], expected[idx], out);
                    n_errors++;
                end
            end
        end
        accepted_q = arst_n && in_valid && in_ready;
        if (accepted_q) begin
            pending.push_back(cur_idx);
        end
    end

    initial begin : watchdog
        wait (n_cases > 0);
        #(2 * n_cases * 20 * 4 + 100);
        $display("timeout: records stopped arriving before all cases were checked");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        inst      = '0;
        out_ready = 1'b0;
        load_cases();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        if (out_valid || !in_ready) begin
            $display("handshake not idle after reset");
            n_errors++;
        end
        if (n_cases > 0) begin
            run_pass(1'b0);
            run_pass(1'b1);
        end
        if (n_checked != 2 * n_cases || n_cases == 0) begin
            $display("record count wrong, %0d of %0d arrived", n_checked, 2 * n_cases);
            n_errors++;
        end
        n_errors += i_dut.i_handshake_assert.fail_count;
        $display("cases %0d, records checked %0d, errors %0d", n_cases, n_checked, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== test/decode_assert.sv ====
`timescale 1ns/1ps

module decode_assert (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       in_ready,
    input logic                       out_valid,
    input logic                       out_ready,
    input rv_decode_pkg::decode_out_t out
);

    int fail_count = 0;

    // stalled record must not move
    property hold_under_stall;
        @(posedge clk) disable iff (!arst_n)
            out_valid && !out_ready |=> out_valid && $stable(out);
    endproperty

    property idle_in_reset;
        @(posedge clk) !arst_n |-> !out_valid;
    endproperty

    property ready_rule;
        @(posedge clk) disable iff (!arst_n)
            in_ready == (!out_valid || out_ready);
    endproperty

    a_hold: assert property (hold_under_stall) else begin
        $error("out changed while stalled");
        fail_count++;
    end
    a_reset: assert property (idle_in_reset) else begin
        $error("out_valid high in reset");
        fail_count++;
    end
    a_ready: assert property (ready_rule) else begin
        $error("in_ready does not follow out side");
        fail_count++;
    end

endmodule

bind decode_top decode_assert i_handshake_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out)
);

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  rv_decode_pkg::inst_t        inst,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv_decode_pkg::decode_out_t  out
);

    rv_decode_pkg::op_class_e op_class;
    rv_decode_pkg::imm_fmt_e  imm_fmt;
    rv_decode_pkg::alu_ctrl_t alu;
    rv_decode_pkg::mem_ctrl_t mem;
    rv_decode_pkg::xlen_t     imm;

    decode_ctrl i_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .op_class  (op_class),
        .imm_fmt   (imm_fmt),
        .alu       (alu),
        .mem       (mem),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    alu_decode i_alu_decode (
        .op_class (op_class),
        .inst     (inst),
        .alu      (alu)
    );

    // format picked by the class in decode_ctrl
    imm_gen i_imm_gen (
        .imm_fmt (imm_fmt),
        .inst    (inst),
        .imm     (imm)
    );

    mem_decode i_mem_decode (
        .op_class (op_class),
        .inst     (inst),
        .mem      (mem)
    );

endmodule

// ==== logic/decode_ctrl.sv ====
`timescale 1ns/1ps

module decode_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  rv_decode_pkg::inst_t        inst,
    output rv_decode_pkg::op_class_e    op_class,
    output rv_decode_pkg::imm_fmt_e     imm_fmt,
    input  rv_decode_pkg::alu_ctrl_t    alu,
    input  rv_decode_pkg::mem_ctrl_t    mem,
    input  rv_decode_pkg::xlen_t        imm,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv_decode_pkg::decode_out_t  out
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    rv_decode_pkg::reg_addr_t rd_f;
    rv_decode_pkg::reg_addr_t rs1_f;
    rv_decode_pkg::reg_addr_t rs2_f;
    logic                     use_rs1;
    logic                     use_rs2;
    logic                     use_rd;
    logic                     jump;
    logic                     jalr;
    logic                     opc_bad;
    logic                     is_ebreak;
    logic                     illegal;
    logic                     accept;
    rv_decode_pkg::decode_out_t rec;

    assign opcode = inst[rv_decode_pkg::OPCODE_LSB +: 7];
    assign funct3 = inst[rv_decode_pkg::FUNCT3_LSB +: 3];
    assign rd_f   = inst[rv_decode_pkg::RD_LSB +: 5];
    assign rs1_f  = inst[rv_decode_pkg::RS1_LSB +: 5];
    assign rs2_f  = inst[rv_decode_pkg::RS2_LSB +: 5];

    always_comb begin
        op_class  = rv_decode_pkg::CLS_NONE;
        imm_fmt   = rv_decode_pkg::IMM_NONE;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_rd    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        opc_bad   = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            rv_decode_pkg::OPC_OP: begin
                op_class = rv_decode_pkg::CLS_OP;
                {use_rs1, use_rs2, use_rd} = 3'b111;
            end
            rv_decode_pkg::OPC_OP_32: begin
                op_class = rv_decode_pkg::CLS_OP_32;
                {use_rs1, use_rs2, use_rd} = 3'b111;
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                op_class = rv_decode_pkg::CLS_OP_IMM;
                imm_fmt  = rv_decode_pkg::IMM_I;
                {use_rs1, use_rd} = 2'b11;
            end
            rv_decode_pkg::OPC_OP_IMM_32: begin
                op_class = rv_decode_pkg::CLS_OP_IMM_32;
                imm_fmt  = rv_decode_pkg::IMM_I;
                {use_rs1, use_rd} = 2'b11;
            end
            rv_decode_pkg::OPC_LOAD: begin
                op_class = rv_decode_pkg::CLS_LOAD;
                imm_fmt  = rv_decode_pkg::IMM_I;
                {use_rs1, use_rd} = 2'b11;
            end
            rv_decode_pkg::OPC_STORE: begin
                op_class = rv_decode_pkg::CLS_STORE;
                imm_fmt  = rv_decode_pkg::IMM_S;
                {use_rs1, use_rs2} = 2'b11;         // base and data, no write
            end
            rv_decode_pkg::OPC_BRANCH: begin
                op_class = rv_decode_pkg::CLS_BRANCH;
                imm_fmt  = rv_decode_pkg::IMM_B;
                {use_rs1, use_rs2} = 2'b11;
            end
            rv_decode_pkg::OPC_JAL: begin
                op_class = rv_decode_pkg::CLS_JAL;
                imm_fmt  = rv_decode_pkg::IMM_J;
                use_rd   = 1'b1;
                jump     = 1'b1;
            end
            rv_decode_pkg::OPC_JALR: begin
                op_class = rv_decode_pkg::CLS_JALR;
                imm_fmt  = rv_decode_pkg::IMM_I;
                {use_rs1, use_rd} = 2'b11;
                jump     = 1'b1;
                jalr     = 1'b1;
                opc_bad  = (funct3 != 3'b000);      // only funct3 0 defined
            end
            rv_decode_pkg::OPC_LUI: begin
                op_class = rv_decode_pkg::CLS_LUI;
                imm_fmt  = rv_decode_pkg::IMM_U;
                use_rd   = 1'b1;                    // x0 + imm
            end
            rv_decode_pkg::OPC_AUIPC: begin
                op_class = rv_decode_pkg::CLS_AUIPC;
                imm_fmt  = rv_decode_pkg::IMM_U;
                use_rd   = 1'b1;
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                op_class  = rv_decode_pkg::CLS_SYSTEM;
                is_ebreak = (inst == rv_decode_pkg::EBREAK_INST);
                opc_bad   = !is_ebreak;             // ecall, csr etc not supported
            end
            default: opc_bad = 1'b1;
        endcase
    end

    assign illegal = opc_bad || !alu.legal || !mem.legal;

    always_comb begin
        rec = '0;
        if (illegal) begin
            rec.illegal = 1'b1;
        end else if (is_ebreak) begin
            rec.ebreak = 1'b1;
        end else begin
            rec.rs1         = use_rs1 ? rs1_f : '0;
            rec.rs2         = use_rs2 ? rs2_f : '0;
            rec.rd          = use_rd ? rd_f : '0;
            rec.reg_wen     = use_rd;
            rec.alu_op      = alu.alu_op;
            rec.src_sel     = alu.src_sel;
            rec.word_op     = alu.word_op;
            rec.br_cond     = alu.br_cond;
            rec.imm         = imm;
            rec.load        = mem.load;
            rec.store       = mem.store;
            rec.size        = mem.size;
            rec.unsigned_ld = mem.unsigned_ld;
            rec.byte_mask   = mem.byte_mask;
            rec.jump        = jump;
            rec.jalr        = jalr;
        end
    end

    // single slot, refills in the cycle it drains
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out <= rec;
        end
    end

endmodule

// ==== logic/mem_decode.sv ====
`timescale 1ns/1ps

module mem_decode (
    input  rv_decode_pkg::op_class_e op_class,
    input  rv_decode_pkg::inst_t     inst,
    output rv_decode_pkg::mem_ctrl_t mem
);

    logic [2:0] funct3;

    assign funct3 = inst[rv_decode_pkg::FUNCT3_LSB +: 3];

    always_comb begin
        mem.load        = 1'b0;
        mem.store       = 1'b0;
        mem.size        = rv_decode_pkg::MEM_BYTE;
        mem.unsigned_ld = 1'b0;
        mem.byte_mask   = 8'h00;
        mem.legal       = 1'b1;
        case (op_class)
            rv_decode_pkg::CLS_LOAD: begin
                if (funct3 == 3'b111) begin
                    mem.legal = 1'b0;               // no ldu on rv64
                end else begin
                    mem.load        = 1'b1;
                    mem.size        = rv_decode_pkg::mem_size_e'(funct3[1:0]);
                    mem.unsigned_ld = funct3[2];
                end
            end
            rv_decode_pkg::CLS_STORE: begin
                if (funct3[2]) begin
                    mem.legal = 1'b0;
                end else begin
                    mem.store = 1'b1;
                    mem.size  = rv_decode_pkg::mem_size_e'(funct3[1:0]);
                    case (funct3[1:0])
                        2'b00:   mem.byte_mask = 8'h01;
                        2'b01:   mem.byte_mask = 8'h03;
                        2'b10:   mem.byte_mask = 8'h0f;
                        default: mem.byte_mask = 8'hff;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::imm_fmt_e imm_fmt,
    input  rv_decode_pkg::inst_t    inst,
    output rv_decode_pkg::xlen_t    imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            rv_decode_pkg::IMM_I: begin
                imm = {{52{sign}}, inst[31:20]};
            end
            rv_decode_pkg::IMM_S: begin
                imm = {{52{sign}}, inst[31:25], inst[11:7]};
            end
            rv_decode_pkg::IMM_B: begin
                // halfword offset, bit 0 always zero
                imm = {{51{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_decode_pkg::IMM_U: begin
                imm = {{32{sign}}, inst[31:12], 12'b0};
            end
            rv_decode_pkg::IMM_J: begin
                imm = {{43{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== logic/alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode (
    input  rv_decode_pkg::op_class_e op_class,
    input  rv_decode_pkg::inst_t     inst,
    output rv_decode_pkg::alu_ctrl_t alu
);

    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                alt;
    logic                f7_zero;
    logic                f7_alt;
    logic                reg_form;
    rv_decode_pkg::alu_op_e base_op;

    assign funct3   = inst[rv_decode_pkg::FUNCT3_LSB +: 3];
    assign funct7   = inst[rv_decode_pkg::FUNCT7_LSB +: 7];
    assign alt      = funct7[5];                    // sub / sra select
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);
    assign reg_form = (op_class == rv_decode_pkg::CLS_OP) ||
                      (op_class == rv_decode_pkg::CLS_OP_32);

    always_comb begin
        case (funct3)
            3'b000:  base_op = (alt && reg_form) ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001:  base_op = rv_decode_pkg::ALU_SLL;
            3'b010:  base_op = rv_decode_pkg::ALU_SLT;
            3'b011:  base_op = rv_decode_pkg::ALU_SLTU;
            3'b100:  base_op = rv_decode_pkg::ALU_XOR;
            3'b101:  base_op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110:  base_op = rv_decode_pkg::ALU_OR;
            default: base_op = rv_decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        alu.alu_op  = rv_decode_pkg::ALU_ADD;
        alu.src_sel = rv_decode_pkg::SRC_REG;
        alu.word_op = 1'b0;
        alu.br_cond = rv_decode_pkg::BR_NONE;
        alu.legal   = 1'b1;
        case (op_class)
            rv_decode_pkg::CLS_OP: begin
                alu.alu_op = base_op;
                alu.legal  = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_decode_pkg::CLS_OP_32: begin
                alu.alu_op  = base_op;
                alu.word_op = 1'b1;
                alu.legal   = (funct3 == 3'b001) ? f7_zero :
                              (funct3 == 3'b000 || funct3 == 3'b101) ? (f7_zero || f7_alt) :
                              1'b0;
            end
            rv_decode_pkg::CLS_OP_IMM: begin
                alu.alu_op  = base_op;
                alu.src_sel = rv_decode_pkg::SRC_IMM;
                // 6-bit shamt, funct7[0] belongs to it
                if (funct3 == 3'b001) begin
                    alu.legal = (funct7[6:1] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    alu.legal = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
                end
            end
            rv_decode_pkg::CLS_OP_IMM_32: begin
                alu.alu_op  = base_op;
                alu.src_sel = rv_decode_pkg::SRC_IMM;
                alu.word_op = 1'b1;
                alu.legal   = (funct3 == 3'b000) ? 1'b1 :
                              (funct3 == 3'b001) ? f7_zero :
                              (funct3 == 3'b101) ? (f7_zero || f7_alt) :
                              1'b0;
            end
            rv_decode_pkg::CLS_LOAD,
            rv_decode_pkg::CLS_STORE,
            rv_decode_pkg::CLS_LUI: alu.src_sel = rv_decode_pkg::SRC_IMM;
            rv_decode_pkg::CLS_AUIPC: alu.src_sel = rv_decode_pkg::SRC_PC_IMM;
            rv_decode_pkg::CLS_JAL,
            rv_decode_pkg::CLS_JALR: alu.src_sel = rv_decode_pkg::SRC_PC_FOUR;
            rv_decode_pkg::CLS_BRANCH: begin
                case (funct3)
                    3'b000: alu.br_cond = rv_decode_pkg::BR_EQ;
                    3'b001: alu.br_cond = rv_decode_pkg::BR_NE;
                    3'b100: alu.br_cond = rv_decode_pkg::BR_LT;
                    3'b101: alu.br_cond = rv_decode_pkg::BR_GE;
                    3'b110: alu.br_cond = rv_decode_pkg::BR_LTU;
                    3'b111: alu.br_cond = rv_decode_pkg::BR_GEU;
                    default: alu.legal  = 1'b0;     // 010, 011 reserved
                endcase
                // compare op for the condition
                alu.alu_op = funct3[2] ? (funct3[1] ? rv_decode_pkg::ALU_SLTU : rv_decode_pkg::ALU_SLT)
                                       : rv_decode_pkg::ALU_SUB;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/rv_decode_pkg.sv ====
package rv_decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [63:0] xlen_t;

    // field positions in the instruction word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam inst_t EBREAK_INST = 32'h0010_0073;

    typedef enum logic [3:0] {
        CLS_NONE, CLS_OP, CLS_OP_IMM, CLS_OP_32, CLS_OP_IMM_32,
        CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL, CLS_JALR,
        CLS_LUI, CLS_AUIPC, CLS_SYSTEM
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // operand b source, pc forms used by auipc and jumps
    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC_IMM, SRC_PC_FOUR} src_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_cond_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD} mem_size_e;

    typedef struct packed {
        alu_op_e  alu_op;
        src_sel_e src_sel;
        logic     word_op;
        br_cond_e br_cond;
        logic     legal;
    } alu_ctrl_t;

    typedef struct packed {
        logic      load;
        logic      store;
        mem_size_e size;
        logic      unsigned_ld;
        logic [7:0] byte_mask;
        logic      legal;
    } mem_ctrl_t;

    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       reg_wen;
        alu_op_e    alu_op;
        src_sel_e   src_sel;
        logic       word_op;
        br_cond_e   br_cond;
        xlen_t      imm;
        logic       load;
        logic       store;
        mem_size_e  size;
        logic       unsigned_ld;
        logic [7:0] byte_mask;
        logic       jump;
        logic       jalr;
        logic       ebreak;
        logic       illegal;
    } decode_out_t;

endpackage
